// File: build.f
src/drp_pkg.sv
src/pll_cfg_pkg.sv
src/setting_select.sv
src/drp_seq.sv
src/lock_mon.sv
src/drp_arbiter.sv
src/pll_model.sv
src/clk_div_chain.sv
src/pll_ctrl.sv
sim/pll_ctrl_checker.sv
sim/tb_pll_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Builds the Verilator model of tb_pll_ctrl, runs it into sim.log and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_pll_ctrl -f build.f -o sim_pll_ctrl \
  || { echo "Verilator build failed."; exit 1; }

./obj_dir/sim_pll_ctrl > sim.log 2>&1

grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed, see sim.log."; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "Simulation ended without a result, see sim.log."; exit 1; }
echo "Simulation passed."
exit 0

// File: sim/pll_ctrl_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pll_ctrl_checker (
  input logic                    clkp,
  input logic                    rstxp,
  input drp_pkg::drp_req_t       pll_req,
  input drp_pkg::drp_rsp_t       pll_rsp,
  input drp_pkg::drp_rsp_t       seq_rsp,
  input drp_pkg::drp_rsp_t       mon_rsp,
  input drp_pkg::drp_owner_e     owner,
  input pll_cfg_pkg::seq_state_e seq_state,
  input logic                    locked,
  input logic                    pll_lock,
  input logic                    div32
);
  import drp_pkg::*;
  import pll_cfg_pkg::*;

  localparam int lock_bound = lock_cycles + 40;

  logic       in_flight;      // A DRP access is between den and drdy.
  logic [7:0] unlocked_idle;  // Cycles since the last sequence ended without pll_lock.

  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      in_flight <= 1'b0;
    end else if (pll_req.den) begin
      in_flight <= 1'b1;
    end else if (pll_rsp.drdy) begin
      in_flight <= 1'b0;
    end
  end

  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      unlocked_idle <= '0;
    end else if (pll_lock || (seq_state != s_idle)) begin
      unlocked_idle <= '0;
    end else if (unlocked_idle != 8'hff) begin
      unlocked_idle <= unlocked_idle + 8'd1;
    end
  end

  a_one_access: assert property (@(posedge clkp) disable iff (!rstxp)
    pll_req.den |-> !in_flight)
    else $error("DRP access started while another one was still outstanding.");

  a_ready_owned: assert property (@(posedge clkp) disable iff (!rstxp)
    pll_rsp.drdy |-> (in_flight && (owner != own_none)))
    else $error("DRP ready arrived with no access outstanding or no bus owner.");

  // The owner is held exactly while an access is in flight and never passes straight
  // from one master to the other.
  a_one_owner: assert property (@(posedge clkp) disable iff (!rstxp)
    !(seq_rsp.drdy && mon_rsp.drdy) &&
    ((seq_rsp.drdy || mon_rsp.drdy) == pll_rsp.drdy) &&
    ((owner == own_none) == !in_flight) &&
    ((owner == own_none) || ($past(owner) == own_none) || (owner == $past(owner))))
    else $error("DRP bus owner is not a single master.");

  // The chain clears one cycle after lock is lost, so two unlocked cycles freeze div32.
  a_div_quiet: assert property (@(posedge clkp) disable iff (!rstxp)
    (!pll_lock && !$past(locked) && !$past(locked, 2)) |-> $stable(div32))
    else $error("div32 moved while the PLL was unlocked.");

  a_lock_in_time: assert property (@(posedge clkp) disable iff (!rstxp)
    unlocked_idle <= 8'(lock_bound))
    else $error("pll_lock did not rise in time after a sequence ended.");

endmodule

bind pll_ctrl pll_ctrl_checker pll_ctrl_checker_i (
  .clkp,
  .rstxp,
  .pll_req,
  .pll_rsp,
  .seq_rsp,
  .mon_rsp,
  .owner(drp_arbiter_i.owner),
  .seq_state(drp_seq_i.state),
  .locked,
  .pll_lock,
  .div32
);

`default_nettype wire

// File: sim/tb_pll_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pll_ctrl;
  import pll_cfg_pkg::*;

  localparam int clk_period       = 8;
  localparam int directed_presses = 8;
  localparam int random_presses   = 24;
  localparam int total_presses    = directed_presses + random_presses;
  localparam int edge_limit       = 16 * (15 + div_base) + 16;
  localparam int settle_limit     = lock_cycles + 40 + 100;

  logic       clkp;
  logic       rstxp;
  logic       btn_up;
  logic       btn_dn;
  logic [6:0] digit0;
  logic [6:0] digit1;
  logic       pll_lock;
  logic       div32;

  logic [3:0]  exp_setting;  // Presses counted modulo 16.
  logic [31:0] rnd_state;
  int          checks;
  int          value_errors;
  int          other_errors;

  pll_ctrl dut_i (
    .clkp, .rstxp, .btn_up, .btn_dn, .digit0, .digit1, .pll_lock, .div32
  );

  initial begin
    clkp = 1'b0;
    forever #(clk_period / 2) clkp = ~clkp;
  end

  initial begin
    repeat (total_presses * 2000) @(posedge clkp);
    $display("Watchdog expired after %0d cycles, the run is stuck.", total_presses * 2000);
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Builds a gfedcba pattern from the names of the lit segments.
  function automatic logic [6:0] segments(input string lit);
    logic [6:0] pat;
    int         idx;
    pat = 7'b0;
    for (int i = 0; i < lit.len(); i++) begin
      idx = int'(lit[i]) - 97;
      pat = pat | (7'b1 << idx);
    end
    return pat;
  endfunction

  function automatic logic [6:0] digit_pattern(input int d);
    string lit;
    case (d)
      0: lit = "abcdef";
      1: lit = "bc";
      2: lit = "abdeg";
      3: lit = "abcdg";
      4: lit = "bcfg";
      5: lit = "acdfg";
      6: lit = "acdefg";
      7: lit = "abc";
      8: lit = "abcdefg";
      9: lit = "abcdfg";
      default: lit = "";
    endcase
    return segments(lit);
  endfunction

  task automatic check_digits(input string name);
    logic [6:0] exp0;
    logic [6:0] exp1;
    exp1 = (exp_setting >= 4'd10) ? digit_pattern(1) : 7'h00;  // Blank tens below ten.
    exp0 = digit_pattern(int'(exp_setting) % 10);
    checks++;
    assert (digit1 == exp1) else begin
      value_errors++;
      $display("** Error %s tens digit: expected 7'h%02h, actual 7'h%02h", name, exp1, digit1);
    end
    assert (digit0 == exp0) else begin
      value_errors++;
      $display("** Error %s ones digit: expected 7'h%02h, actual 7'h%02h", name, exp0, digit0);
    end
  endtask

  // A 3-cycle pulse. The step lands on the edge that sees the release.
  task automatic press_button(input logic up, input string name);
    if (up) btn_up = 1'b1;
    else btn_dn = 1'b1;
    repeat (3) begin
      @(posedge clkp);
      #1;
    end
    btn_up = 1'b0;
    btn_dn = 1'b0;
    exp_setting = up ? exp_setting + 4'd1 : exp_setting - 4'd1;
    @(posedge clkp);
    #1;
    check_digits(name);
  endtask

  task automatic wait_lock_level(input logic level, input int limit, input string name);
    int    cycles;
    string dir;
    cycles = 0;
    if (level) dir = "high";
    else dir = "low";
    while ((pll_lock !== level) && (cycles < limit)) begin
      @(posedge clkp);
      #1;
      cycles++;
    end
    checks++;
    assert (pll_lock === level) else begin
      other_errors++;
      $display("%s: pll_lock did not go %s within %0d cycles.", name, dir, limit);
    end
  endtask

  task automatic wait_div_edge(output int cycles, output logic ok);
    logic prev;
    prev = div32;
    cycles = 0;
    while ((div32 == prev) && (cycles < edge_limit)) begin
      @(posedge clkp);
      #1;
      cycles++;
    end
    ok = (div32 != prev);
  endtask

  task automatic measure_half_periods(input string name);
    int   expected;
    int   cycles;
    logic ok;
    expected = 16 * (int'(exp_setting) + div_base);
    wait_div_edge(cycles, ok);  // Aligns to an edge. The first half may be partial.
    repeat (2) begin
      wait_div_edge(cycles, ok);
      checks++;
      assert (ok) else begin
        other_errors++;
        $display("%s: div32 stopped toggling while the PLL was locked.", name);
      end
      if (ok) begin
        assert (cycles == expected) else begin
          value_errors++;
          $display("** Error %s div32 half-period: expected %0d, actual %0d", name, expected,
                   cycles);
        end
      end
    end
  endtask

  task automatic settle_and_measure(input string name);
    wait_lock_level(1'b0, 80, name);
    wait_lock_level(1'b1, settle_limit, name);
    measure_half_periods(name);
  endtask

  task automatic check_quiet_after_reset();
    int high_cycles;
    high_cycles = 0;
    repeat (lock_cycles) begin
      if (pll_lock || div32) high_cycles++;
      @(posedge clkp);
      #1;
    end
    checks++;
    assert (high_cycles == 0) else begin
      value_errors++;
      $display("** Error after reset: expected 0 high cycles of pll_lock or div32, actual %0d",
               high_cycles);
    end
  endtask

  initial begin
    logic [31:0] r;
    logic        settled;
    btn_up       = 1'b0;
    btn_dn       = 1'b0;
    rstxp        = 1'b0;
    exp_setting  = 4'd0;
    rnd_state    = 32'h3118;
    checks       = 0;
    value_errors = 0;
    other_errors = 0;
    settled      = 1'b0;
    repeat (8) @(posedge clkp);
    #1 rstxp = 1'b1;

    check_digits("reset");
    check_quiet_after_reset();
    wait_lock_level(1'b1, lock_cycles + 80, "first lock");
    measure_half_periods("setting 0");

    press_button(1'b0, "down wrap");
    settle_and_measure("setting 15");
    press_button(1'b1, "up wrap");
    repeat (3) @(posedge clkp);
    #1;

    // Presses closer together than one sequence.
    for (int i = 0; i < 6; i++) begin
      press_button(i < 5, $sformatf("burst %0d", i));
      repeat (2) @(posedge clkp);
      #1;
    end
    settle_and_measure("burst");
    settled = 1'b1;

    for (int i = 0; i < random_presses; i++) begin
      rnd_state = xorshift32(rnd_state);
      r = rnd_state;
      press_button(r[0], $sformatf("press %0d", i));
      if (r[5:3] < 3'd5) begin
        repeat (int'(r[10:8]) % 7) @(posedge clkp);
        #1;
        settled = 1'b0;
      end else begin
        settle_and_measure($sformatf("long gap %0d", i));
        settled = 1'b1;
      end
    end
    // A last press with a short gap has not been measured yet.
    if (!settled) begin
      settle_and_measure("final");
    end

    $display("Checks: %0d, value errors: %0d, other errors: %0d", checks, value_errors,
             other_errors);
    if (value_errors + other_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/clk_div_chain.sv
`timescale 1ns/1ps
`default_nettype none

module clk_div_chain (
  input  logic       clkp,
  input  logic       rstxp,
  input  logic       locked,
  input  logic [4:0] out_div,
  output logic       div32
);
  import pll_cfg_pkg::*;

  logic [4:0]            cnt;
  logic                  tick;  // One output clock of the modelled PLL.
  logic [div_stages-1:0] stg;
  logic [div_stages-1:0] stg_q;

  assign tick = (cnt == out_div - 5'd1);

  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      cnt   <= '0;
      stg   <= '0;
      stg_q <= '0;
    end else if (!locked) begin
      cnt   <= '0;  // Losing lock restarts the whole chain.
      stg   <= '0;
      stg_q <= '0;
    end else begin
      cnt   <= tick ? 5'd0 : cnt + 5'd1;
      stg_q <= stg;
      if (tick) stg[0] <= ~stg[0];
      for (int i = 1; i < div_stages; i++) begin
        if (stg[i-1] & ~stg_q[i-1]) stg[i] <= ~stg[i];
      end
    end
  end

  assign div32 = stg[div_stages-1];

endmodule

`default_nettype wire

// File: src/drp_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module drp_arbiter (
  input  logic              clkp,
  input  logic              rstxp,
  input  drp_pkg::drp_req_t seq_req,
  output drp_pkg::drp_rsp_t seq_rsp,
  input  drp_pkg::drp_req_t mon_req,
  output drp_pkg::drp_rsp_t mon_rsp,
  output drp_pkg::drp_req_t pll_req,
  input  drp_pkg::drp_rsp_t pll_rsp
);
  import drp_pkg::*;

  drp_owner_e owner;
  drp_req_t   seq_hold;
  drp_req_t   mon_hold;
  drp_req_t   seq_cur;
  drp_req_t   mon_cur;
  logic       seq_hold_v;
  logic       mon_hold_v;
  logic       seq_want;
  logic       mon_want;
  logic       grant_seq;
  logic       grant_mon;

  assign seq_want = seq_req.den | seq_hold_v;
  assign mon_want = mon_req.den | mon_hold_v;
  assign seq_cur  = seq_hold_v ? seq_hold : seq_req;
  assign mon_cur  = mon_hold_v ? mon_hold : mon_req;

  // The sequencer wins when both ask in the same cycle.
  assign grant_seq = (owner == own_none) & seq_want;
  assign grant_mon = (owner == own_none) & ~seq_want & mon_want;

  always_comb begin
    pll_req     = grant_mon ? mon_cur : seq_cur;
    pll_req.den = grant_seq | grant_mon;
  end

  assign seq_rsp = '{drdy: pll_rsp.drdy & (owner == own_seq), dout: pll_rsp.dout};
  assign mon_rsp = '{drdy: pll_rsp.drdy & (owner == own_mon), dout: pll_rsp.dout};

  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      owner      <= own_none;
      seq_hold_v <= 1'b0;
      mon_hold_v <= 1'b0;
    end else begin
      if (pll_rsp.drdy)   owner <= own_none;
      else if (grant_seq) owner <= own_seq;
      else if (grant_mon) owner <= own_mon;
      seq_hold_v <= seq_want & ~grant_seq;
      mon_hold_v <= mon_want & ~grant_mon;
    end
  end

  always_ff @(posedge clkp) begin
    if (seq_req.den) seq_hold <= seq_req;
    if (mon_req.den) mon_hold <= mon_req;
  end

endmodule

`default_nettype wire

// File: src/drp_pkg.sv
`default_nettype none

package drp_pkg;

  // One access from a master. The den strobe is high for a single cycle.
  typedef struct packed {
    logic        den;
    logic        dwe;
    logic [4:0]  daddr;
    logic [15:0] di;
  } drp_req_t;

  typedef struct packed {
    logic        drdy;  // One-cycle pulse, drp_latency cycles after den.
    logic [15:0] dout;
  } drp_rsp_t;

  typedef enum logic [1:0] {
    own_none,
    own_seq,
    own_mon
  } drp_owner_e;

  localparam logic [4:0] reg_ctrl   = 5'd0;  // Bit 0 holds the PLL in reset.
  localparam logic [4:0] reg_div    = 5'd1;
  localparam logic [4:0] reg_mult   = 5'd2;
  localparam logic [4:0] reg_status = 5'd3;  // Read-only, bit 0 is locked.

  localparam int drp_latency = 2;

endpackage

`default_nettype wire

// File: src/drp_seq.sv
`timescale 1ns/1ps
`default_nettype none

module drp_seq (
  input  logic                             clkp,
  input  logic                             rstxp,
  input  logic [pll_cfg_pkg::setting_w-1:0] setting,
  input  logic                             change,
  output drp_pkg::drp_req_t                req,
  input  drp_pkg::drp_rsp_t                rsp
);
  import drp_pkg::*;
  import pll_cfg_pkg::*;

  seq_state_e state;
  logic       pending;
  logic       issued;
  logic       start;

  assign start = pending | change;

  // Each write state strobes den once on entry and then waits for drdy.
  always_comb begin
    req.den = (state != s_idle) && !issued;
    req.dwe = 1'b1;
    case (state)
      s_rst: begin
        req.daddr = reg_ctrl;
        req.di    = 16'd1;
      end
      s_div: begin
        req.daddr = reg_div;
        req.di    = 16'(setting) + 16'(div_base);
      end
      s_mult: begin
        req.daddr = reg_mult;
        req.di    = 16'(mult_value);
      end
      default: begin
        req.daddr = reg_ctrl;  // Release of the PLL reset in s_run.
        req.di    = 16'd0;
      end
    endcase
  end

  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      state   <= s_idle;
      pending <= 1'b1;  // First sequence runs with setting 0.
      issued  <= 1'b0;
    end else begin
      if (req.den) issued <= 1'b1;
      if (change)  pending <= 1'b1;
      case (state)
        s_idle: begin
          if (start) begin
            state   <= s_rst;
            pending <= 1'b0;
          end
        end
        s_rst:  if (rsp.drdy) state <= s_div;
        s_div:  if (rsp.drdy) state <= s_mult;
        s_mult: if (rsp.drdy) state <= s_run;
        s_run: begin
          if (rsp.drdy) begin
            pending <= 1'b0;
            state   <= start ? s_rst : s_idle;  // Rerun with the latest setting.
          end
        end
        default: state <= s_idle;
      endcase
      if (rsp.drdy) issued <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/lock_mon.sv
`timescale 1ns/1ps
`default_nettype none

module lock_mon (
  input  logic              clkp,
  input  logic              rstxp,
  output drp_pkg::drp_req_t req,
  input  drp_pkg::drp_rsp_t rsp,
  output logic              pll_lock
);
  import drp_pkg::*;
  import pll_cfg_pkg::*;

  logic [poll_cnt_w-1:0] cnt;
  logic                  waiting;
  logic                  poll;

  assign poll = (cnt == poll_cnt_w'(poll_interval - 1)) && !waiting;

  assign req = '{den: poll, dwe: 1'b0, daddr: reg_status, di: 16'd0};

  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      cnt      <= '0;
      waiting  <= 1'b0;
      pll_lock <= 1'b0;
    end else begin
      if (poll) begin
        cnt     <= '0;
        waiting <= 1'b1;
      end else if (!waiting) begin
        cnt <= cnt + 1'b1;  // The interval restarts only after each reply.
      end
      if (rsp.drdy) begin
        waiting  <= 1'b0;
        pll_lock <= rsp.dout[0];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/pll_cfg_pkg.sv
`default_nettype none

package pll_cfg_pkg;

  localparam int setting_w = 4;

  // Output divide is setting + div_base, so it runs from 2 to 17.
  localparam int div_base   = 2;
  localparam int mult_value = 40;

  localparam int lock_cycles   = 64;
  localparam int poll_interval = 16;
  localparam int lock_cnt_w    = $clog2(lock_cycles + 1);
  localparam int poll_cnt_w    = $clog2(poll_interval);

  localparam int div_stages = 5;  // 2**5 output ticks per div32 period.

  typedef enum logic [2:0] {
    s_idle,
    s_rst,
    s_div,
    s_mult,
    s_run
  } seq_state_e;

  // Pattern is gfedcba with segment a in bit 0.
  function automatic logic [6:0] seg7(input logic [3:0] digit);
    logic [6:0] pat;
    case (digit)
      4'd0:    pat = 7'b0111111;
      4'd1:    pat = 7'b0000110;
      4'd2:    pat = 7'b1011011;
      4'd3:    pat = 7'b1001111;
      4'd4:    pat = 7'b1100110;
      4'd5:    pat = 7'b1101101;
      4'd6:    pat = 7'b1111101;
      4'd7:    pat = 7'b0000111;
      4'd8:    pat = 7'b1111111;
      4'd9:    pat = 7'b1101111;
      default: pat = 7'b0000000;
    endcase
    return pat;
  endfunction

endpackage

`default_nettype wire

// File: src/pll_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pll_ctrl (
  input  logic       clkp,
  input  logic       rstxp,
  input  logic       btn_up,
  input  logic       btn_dn,
  output logic [6:0] digit0,
  output logic [6:0] digit1,
  output logic       pll_lock,
  output logic       div32
);
  import drp_pkg::*;
  import pll_cfg_pkg::*;

  logic [setting_w-1:0] setting;
  logic                 change;
  logic                 locked;
  logic [4:0]           out_div;
  drp_req_t             seq_req;
  drp_req_t             mon_req;
  drp_req_t             pll_req;
  drp_rsp_t             seq_rsp;
  drp_rsp_t             mon_rsp;
  drp_rsp_t             pll_rsp;

  setting_select setting_select_i (
    .clkp, .rstxp, .btn_up, .btn_dn, .setting, .change, .digit0, .digit1
  );

  drp_seq drp_seq_i (
    .clkp, .rstxp, .setting, .change, .req(seq_req), .rsp(seq_rsp)
  );

  lock_mon lock_mon_i (.clkp, .rstxp, .req(mon_req), .rsp(mon_rsp), .pll_lock);

  drp_arbiter drp_arbiter_i (
    .clkp, .rstxp, .seq_req, .seq_rsp, .mon_req, .mon_rsp, .pll_req, .pll_rsp
  );

  // Stands in for the vendor PLL, its output clock is a tick on clkp.
  pll_model pll_model_i (
    .clkp, .rstxp, .req(pll_req), .rsp(pll_rsp), .locked, .out_div
  );

  clk_div_chain clk_div_chain_i (.clkp, .rstxp, .locked, .out_div, .div32);

endmodule

`default_nettype wire

// File: src/pll_model.sv
`timescale 1ns/1ps
`default_nettype none

module pll_model (
  input  logic              clkp,
  input  logic              rstxp,
  input  drp_pkg::drp_req_t req,
  output drp_pkg::drp_rsp_t rsp,
  output logic              locked,
  output logic [4:0]        out_div
);
  import drp_pkg::*;
  import pll_cfg_pkg::*;

  logic                   pll_rst;
  logic [15:0]            div_reg;
  logic [15:0]            mult_reg;
  logic [15:0]            rd_data;
  logic [lock_cnt_w-1:0]  lock_cnt;
  logic [drp_latency-1:0] rdy_pipe;
  logic [15:0]            data_pipe [drp_latency];

  assign locked = ~pll_rst & (lock_cnt == lock_cnt_w'(lock_cycles));

  always_comb begin
    case (req.daddr)
      reg_ctrl:   rd_data = {15'd0, pll_rst};
      reg_div:    rd_data = div_reg;
      reg_mult:   rd_data = mult_reg;
      reg_status: rd_data = {15'd0, locked};
      default:    rd_data = 16'd0;
    endcase
  end

  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      pll_rst  <= 1'b1;
      div_reg  <= 16'(div_base);
      mult_reg <= 16'(mult_value);
      out_div  <= 5'(div_base);
      lock_cnt <= '0;
      rdy_pipe <= '0;
    end else begin
      if (req.den && req.dwe) begin
        case (req.daddr)
          reg_ctrl: begin
            pll_rst <= req.di[0];
            if (!req.di[0]) out_div <= div_reg[4:0];  // Divide takes effect on release.
          end
          reg_div:  div_reg  <= req.di;
          reg_mult: mult_reg <= req.di;
          default:  ;
        endcase
      end
      if (pll_rst) lock_cnt <= '0;
      else if (!locked) lock_cnt <= lock_cnt + 1'b1;
      rdy_pipe <= {rdy_pipe[drp_latency-2:0], req.den};
    end
  end

  // Read data is taken on the den cycle and travels with the ready bit.
  always_ff @(posedge clkp) begin
    data_pipe[0] <= rd_data;
    for (int i = 1; i < drp_latency; i++) data_pipe[i] <= data_pipe[i-1];
  end

  assign rsp = '{drdy: rdy_pipe[drp_latency-1], dout: data_pipe[drp_latency-1]};

endmodule

`default_nettype wire

// File: src/setting_select.sv
`timescale 1ns/1ps
`default_nettype none

module setting_select (
  input  logic                             clkp,
  input  logic                             rstxp,
  input  logic                             btn_up,
  input  logic                             btn_dn,
  output logic [pll_cfg_pkg::setting_w-1:0] setting,
  output logic                             change,
  output logic [6:0]                       digit0,
  output logic [6:0]                       digit1
);
  import pll_cfg_pkg::*;

  logic                 btn_up_q;
  logic                 btn_dn_q;
  logic                 up_fall;
  logic                 dn_fall;
  logic                 stepped;
  logic                 tens;
  logic [setting_w-1:0] ones;

  // A release is seen when the live input is low and the last sample was high.
  assign up_fall = ~btn_up & btn_up_q;
  assign dn_fall = ~btn_dn & btn_dn_q;

  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      btn_up_q <= 1'b0;
      btn_dn_q <= 1'b0;
    end else begin
      btn_up_q <= btn_up;
      btn_dn_q <= btn_dn;
    end
  end

  always_ff @(posedge clkp or negedge rstxp) begin
    if (!rstxp) begin
      setting <= '0;
      stepped <= 1'b0;
      change  <= 1'b0;
    end else begin
      if (dn_fall) begin
        setting <= setting - 1'b1;  // Wraps from 0 to 15.
      end else if (up_fall) begin
        setting <= setting + 1'b1;
      end
      stepped <= up_fall | dn_fall;
      change  <= stepped;  // Strobe lags the new setting by one cycle.
    end
  end

  assign tens = (setting > setting_w'(9));
  assign ones = tens ? setting - setting_w'(10) : setting;

  // The tens digit stays dark below ten.
  assign digit1 = tens ? seg7(4'd1) : 7'b0000000;
  assign digit0 = seg7(ones);

endmodule

`default_nettype wire
